//--- src/kicker_pkg.sv
/*
 * Shared definitions for the ROM download path
 *   SDRAM region offsets and the colour PROM window
 *   Handshake timeout length
 *   Region and download FSM state enums
 */
`default_nettype none

package kicker_pkg;

    // Byte offsets inside the downloaded ROM image
    localparam logic [24:0] SCR_START  = 25'h001_0000;
    localparam logic [24:0] OBJ_START  = 25'h001_8000;
    localparam logic [24:0] PROM_START = 25'h002_0000;
    localparam logic [24:0] PROM_END   = 25'h002_0200; // Bytes past this are ignored

    localparam int PROM_AW = 9;         // 512 colour entries

    // Cycles allowed per handshake phase
    localparam int ACK_TIMEOUT = 64;

    typedef enum logic [1:0] {
        REG_MAIN,
        REG_SCR,
        REG_OBJ,
        REG_PROM
    } region_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,     // prog_we high, waiting for ack
        ST_RELEASE  // prog_we low, waiting for ack to drop
    } dwnld_state_t;

endpackage

`default_nettype wire

//--- src/kicker_prog_latch.sv
/*
 * Download byte latch
 *   Region decode of the incoming ioctl address
 *   Tile and sprite address bit reordering
 *   Registered SDRAM address, data byte and byte mask
 */
`timescale 1ns/1ps
`default_nettype none

module kicker_prog_latch (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [24:0]         ioctl_addr,
    input  logic [7:0]          ioctl_dout,
    input  logic                capture,
    output logic [21:0]         prog_addr,
    output logic [7:0]          prog_data,
    output logic [1:0]          prog_mask,  // Active low
    output kicker_pkg::region_t region
);
    import kicker_pkg::*;

    region_t     dec_region;
    logic [21:0] word_addr;
    logic [21:0] swz_addr;

    assign word_addr = ioctl_addr[22:1];

    always_comb begin
        if (ioctl_addr < SCR_START) begin
            dec_region = REG_MAIN;
        end else if (ioctl_addr < OBJ_START) begin
            dec_region = REG_SCR;
        end else if (ioctl_addr < PROM_START) begin
            dec_region = REG_OBJ;
        end else begin
            dec_region = REG_PROM;
        end
    end

    // Video fetch expects the half-tile bit at the bottom
    always_comb begin
        swz_addr = word_addr;
        case (dec_region)
            REG_SCR: begin
                swz_addr[0]   = ~word_addr[3];
                swz_addr[3:1] = word_addr[2:0];
            end
            REG_OBJ: begin
                swz_addr[0]   = ~word_addr[3];
                swz_addr[1]   = ~word_addr[4];
                swz_addr[4:2] = word_addr[2:0];
                swz_addr[5]   = word_addr[5];  // Stays in place
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prog_mask <= 2'b11;     // No byte lane selected
            region    <= REG_MAIN;
        end else if (capture) begin
            prog_mask <= ioctl_addr[0] ? 2'b01 : 2'b10;
            region    <= dec_region;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            prog_addr <= swz_addr;
            prog_data <= ioctl_dout;
        end
    end

endmodule

`default_nettype wire

//--- src/kicker_dwnld_fsm.sv
/*
 * Download write FSM
 *   Accepts SDRAM-bound bytes while idle
 *   Four-phase prog_we / sdram_ack handshake
 *   Abort on timer expiry, sticky timeout and overrun flags
 */
`timescale 1ns/1ps
`default_nettype none

module kicker_dwnld_fsm (
    input  logic clk,
    input  logic rst_n,
    input  logic downloading,
    input  logic wr_sdram,
    input  logic sdram_ack,
    input  logic expired,
    output logic capture,
    output logic prog_we,
    output logic timer_run,
    output logic dwnld_busy,
    output logic ack_timeout,
    output logic overrun
);
    import kicker_pkg::*;

    dwnld_state_t state;
    dwnld_state_t state_nx;
    logic         abort;
    logic         dl_q;
    logic         dl_rise;

    always_comb begin
        state_nx = state;
        abort    = 1'b0;
        case (state)
            ST_IDLE: begin
                if (wr_sdram) state_nx = ST_REQ;
            end
            ST_REQ: begin
                if (sdram_ack) begin
                    state_nx = ST_RELEASE;
                end else if (expired) begin
                    state_nx = ST_IDLE;
                    abort    = 1'b1;
                end
            end
            ST_RELEASE: begin
                if (!sdram_ack) begin
                    state_nx = ST_IDLE;
                end else if (expired) begin  // Ack stuck high
                    state_nx = ST_IDLE;
                    abort    = 1'b1;
                end
            end
            default: state_nx = ST_IDLE;
        endcase
    end

    assign capture    = (state == ST_IDLE) && wr_sdram;
    assign timer_run  = (state != ST_IDLE);
    assign dwnld_busy = downloading || (state != ST_IDLE);
    assign dl_rise    = downloading && !dl_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            prog_we <= 1'b0;
        end else begin
            state   <= state_nx;
            prog_we <= (state_nx == ST_REQ);
        end
    end

    // Error flags hold until the next download starts
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dl_q        <= 1'b0;
            ack_timeout <= 1'b0;
            overrun     <= 1'b0;
        end else begin
            dl_q <= downloading;
            if (dl_rise) begin
                ack_timeout <= 1'b0;
                overrun     <= 1'b0;
            end
            if (abort) ack_timeout <= 1'b1;
            if (wr_sdram && state != ST_IDLE) overrun <= 1'b1; // Byte dropped
        end
    end

endmodule

`default_nettype wire

//--- src/kicker_ack_timer.sv
/*
 * Handshake watchdog
 *   Counts cycles while a phase is pending
 *   Flags expiry after ACK_TIMEOUT cycles
 */
`timescale 1ns/1ps
`default_nettype none

module kicker_ack_timer (
    input  logic clk,
    input  logic rst_n,
    input  logic run,
    input  logic restart,  // Pulsed on each state change
    output logic expired
);
    import kicker_pkg::*;

    logic [7:0] count;

    assign expired = (count == 8'(ACK_TIMEOUT));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= 8'd0;
        end else if (restart) begin
            count <= 8'd0;
        end else if (run && !expired) begin
            count <= count + 8'd1;  // Saturates at the limit
        end
    end

endmodule

`default_nettype wire

//--- src/kicker_prom_store.sv
/*
 * Colour PROM
 *   512 x 4-bit RAM loaded during download
 *   Registered read port for the video side
 */
`timescale 1ns/1ps
`default_nettype none

module kicker_prom_store (
    input  logic                          clk,
    input  logic                          we,
    input  logic [kicker_pkg::PROM_AW-1:0] wr_addr,
    input  logic [3:0]                    wr_data,
    input  logic [kicker_pkg::PROM_AW-1:0] rd_addr,
    output logic [3:0]                    rd_data
);
    import kicker_pkg::*;

    logic [3:0] mem [0:(1 << PROM_AW) - 1];

    always_ff @(posedge clk) begin
        if (we) mem[wr_addr] <= wr_data;
    end

    // One cycle read latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

//--- src/kicker_rom_loader.sv
/*
 * ROM download path top level
 *   Region split between SDRAM and colour PROM writes
 *   Byte latch, handshake FSM, ack watchdog and PROM store
 */
`timescale 1ns/1ps
`default_nettype none

module kicker_rom_loader (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        downloading,
    input  logic [24:0] ioctl_addr,
    input  logic [7:0]  ioctl_dout,
    input  logic        ioctl_wr,
    input  logic        sdram_ack,
    input  logic [8:0]  prom_rd_addr,
    output logic [21:0] prog_addr,
    output logic [7:0]  prog_data,
    output logic [1:0]  prog_mask,   // Active low
    output logic        prog_we,
    output logic        dwnld_busy,
    output logic        ack_timeout,
    output logic        overrun,
    output logic [3:0]  prom_rd_data
);
    import kicker_pkg::*;

    logic        wr_sdram;
    logic        prom_we;
    logic [24:0] prom_offset;
    logic        capture;
    logic        timer_run;
    logic        timer_restart;
    logic        expired;

    assign prom_offset = ioctl_addr - PROM_START;

    // SDRAM below the PROM, PROM inside its window, nothing above
    always_comb begin
        wr_sdram = 1'b0;
        prom_we  = 1'b0;
        if (downloading && ioctl_wr) begin
            if (ioctl_addr < PROM_START) begin
                wr_sdram = 1'b1;
            end else if (ioctl_addr < PROM_END) begin
                prom_we = 1'b1;
            end
        end
    end

    assign timer_restart = capture || (prog_we && sdram_ack); // Entering a new phase

    kicker_prog_latch i_kicker_prog_latch (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .ioctl_addr ( ioctl_addr ),
        .ioctl_dout ( ioctl_dout ),
        .capture    ( capture    ),
        .prog_addr  ( prog_addr  ),
        .prog_data  ( prog_data  ),
        .prog_mask  ( prog_mask  ),
        .region     (            )
    );

    kicker_dwnld_fsm i_kicker_dwnld_fsm (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .downloading ( downloading ),
        .wr_sdram    ( wr_sdram    ),
        .sdram_ack   ( sdram_ack   ),
        .expired     ( expired     ),
        .capture     ( capture     ),
        .prog_we     ( prog_we     ),
        .timer_run   ( timer_run   ),
        .dwnld_busy  ( dwnld_busy  ),
        .ack_timeout ( ack_timeout ),
        .overrun     ( overrun     )
    );

    kicker_ack_timer i_kicker_ack_timer (
        .clk     ( clk           ),
        .rst_n   ( rst_n         ),
        .run     ( timer_run     ),
        .restart ( timer_restart ),
        .expired ( expired       )
    );

    kicker_prom_store i_kicker_prom_store (
        .clk     ( clk                       ),
        .we      ( prom_we                   ),
        .wr_addr ( prom_offset[PROM_AW-1:0]  ),
        .wr_data ( ioctl_dout[3:0]           ),
        .rd_addr ( prom_rd_addr              ),
        .rd_data ( prom_rd_data              )
    );

endmodule

`default_nettype wire

//--- tests/kicker_sdram_model.sv
/*
 * SDRAM controller stand-in for the download handshake
 *   Raises sdram_ack 1 to 8 cycles after prog_we rises
 *   Drops sdram_ack once prog_we falls, never acks while no_ack is set
 */
`timescale 1ns/1ps
`default_nettype none

module kicker_sdram_model (
    input  logic clk,
    input  logic rst_n,
    input  logic prog_we,
    input  logic no_ack,
    output logic sdram_ack
);
    logic       counting;
    logic [3:0] delay;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sdram_ack <= 1'b0;
            counting  <= 1'b0;
            delay     <= 4'd0;
        end else if (sdram_ack) begin
            if (!prog_we) sdram_ack <= 1'b0;  // Phase 4
        end else if (counting) begin
            if (delay == 4'd1) begin
                sdram_ack <= 1'b1;
                counting  <= 1'b0;
            end else begin
                delay <= delay - 4'd1;
            end
        end else if (prog_we && !no_ack) begin
            counting <= 1'b1;
            delay    <= 4'($urandom % 8 + 1);
        end
    end

endmodule

`default_nettype wire

//--- tests/tb_kicker_rom_loader.sv
/*
 * Testbench for the ROM download path
 *   Vector-driven ioctl writes with expected results from the testdata file
 *   Handshake monitor, PROM readback and a run watchdog
 */
`timescale 1ns/1ps
`default_nettype none

module tb_kicker_rom_loader;
    import kicker_pkg::*;

    localparam int MAX_VEC = 32;
    localparam int COLS    = 6;     // Words per testdata line

    logic        clk;
    logic        rst_n;
    logic        downloading;
    logic [24:0] ioctl_addr;
    logic [7:0]  ioctl_dout;
    logic        ioctl_wr;
    logic        sdram_ack;
    logic [8:0]  prom_rd_addr;
    logic [21:0] prog_addr;
    logic [7:0]  prog_data;
    logic [1:0]  prog_mask;
    logic        prog_we;
    logic        dwnld_busy;
    logic        ack_timeout;
    logic        overrun;
    logic [3:0]  prom_rd_data;
    logic        no_ack;

    logic [31:0] vec [0:MAX_VEC*COLS-1];
    logic [3:0]  prom_exp [0:511];
    logic        prom_set [0:511];
    int          num_vec;
    int          errors;
    int          hs_errors;
    int          tests_ok;
    int          tests_bad;
    int          req_count;
    string       test_name;
    logic        we_q;
    logic        ack_q;
    logic [31:0] hold_q;

    kicker_rom_loader i_kicker_rom_loader (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .downloading  ( downloading  ),
        .ioctl_addr   ( ioctl_addr   ),
        .ioctl_dout   ( ioctl_dout   ),
        .ioctl_wr     ( ioctl_wr     ),
        .sdram_ack    ( sdram_ack    ),
        .prom_rd_addr ( prom_rd_addr ),
        .prog_addr    ( prog_addr    ),
        .prog_data    ( prog_data    ),
        .prog_mask    ( prog_mask    ),
        .prog_we      ( prog_we      ),
        .dwnld_busy   ( dwnld_busy   ),
        .ack_timeout  ( ack_timeout  ),
        .overrun      ( overrun      ),
        .prom_rd_data ( prom_rd_data )
    );

    kicker_sdram_model i_kicker_sdram_model (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .prog_we   ( prog_we   ),
        .no_ack    ( no_ack    ),
        .sdram_ack ( sdram_ack )
    );

    always #5 clk = ~clk;

    // Four-phase rules, sampled on pre-edge values
    always @(posedge clk) begin
        if (rst_n) begin
            if (prog_we && !we_q) begin
                req_count++;
                if (sdram_ack) begin
                    $display("ERROR %s: prog_we rose while sdram_ack was high", test_name);
                    hs_errors++;
                end
            end
            if (!prog_we && we_q && !ack_q && !no_ack) begin
                $display("ERROR %s: prog_we fell before sdram_ack rose", test_name);
                hs_errors++;
            end
            if ((we_q || ack_q) && {prog_mask, prog_data, prog_addr} != hold_q) begin
                $display("ERROR %s: prog port changed during a handshake", test_name);
                hs_errors++;
            end
        end
        we_q   <= prog_we;
        ack_q  <= sdram_ack;
        hold_q <= {prog_mask, prog_data, prog_addr};
    end

    function automatic int total_errors();
        return errors + hs_errors;
    endfunction

    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic flag_mismatch(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
        $display("CHECK FAILED %s: %s expected %h actual %h", test_name, what, exp, act);
        errors++;
    endtask

    task automatic note_error(input string msg);
        $display("ERROR %s: %s", test_name, msg);
        errors++;
    endtask

    task automatic ioctl_write(input logic [24:0] addr, input logic [7:0] data);
        ioctl_addr = addr;
        ioctl_dout = data;
        ioctl_wr   = 1'b1;
        step_cycle();
        ioctl_wr   = 1'b0;
    endtask

    task automatic wait_idle();
        while (prog_we || sdram_ack) step_cycle();
        step_cycle();  // FSM sees the ack low one edge later
    endtask

    task automatic restart_download();
        downloading = 1'b0;
        step_cycle();
        if (dwnld_busy !== 1'b0) note_error("dwnld_busy high with no download and the FSM idle");
        downloading = 1'b1;
        step_cycle();
    endtask

    task automatic check_request(input logic [21:0] exp_a, input logic [7:0] data,
                                 input logic [1:0] mask);
        if (prog_we !== 1'b1) note_error("no request one cycle after the write");
        if (prog_addr !== exp_a) flag_mismatch("prog_addr", 32'(exp_a), 32'(prog_addr));
        if (prog_data !== data) flag_mismatch("prog_data", 32'(data), 32'(prog_data));
        if (prog_mask !== mask) flag_mismatch("prog_mask", 32'(mask), 32'(prog_mask));
    endtask

    task automatic close_test(input int errs_before);
        if (total_errors() == errs_before) begin
            tests_ok++;
            $display("ok      %s", test_name);
        end else begin
            tests_bad++;
            $display("FAILED  %s", test_name);
        end
    endtask

    task automatic run_vector(input int idx);
        logic [24:0] addr;
        logic [7:0]  data;
        logic [21:0] exp_a;
        logic [1:0]  mask;
        logic [3:0]  kind;
        logic        err;
        int          errs_before;
        int          reqs_before;
        int          cycles;

        addr  = vec[idx*COLS][24:0];
        data  = vec[idx*COLS+1][7:0];
        exp_a = vec[idx*COLS+2][21:0];
        mask  = vec[idx*COLS+3][1:0];
        kind  = vec[idx*COLS+4][3:0];
        err   = vec[idx*COLS+5][0];
        wait_idle();
        errs_before = total_errors();
        reqs_before = req_count;
        case (kind)
            4'h0: begin
                test_name = $sformatf("sdram %h", addr);
                ioctl_write(addr, data);
                check_request(exp_a, data, mask);
                wait_idle();
                if (req_count != reqs_before + 1) note_error("expected exactly one request");
                if (ack_timeout || overrun) note_error("error flag raised on a clean write");
                if (dwnld_busy !== 1'b1) note_error("dwnld_busy low during a download");
            end
            4'h1, 4'h3: begin
                test_name = $sformatf("%s %h", (kind == 4'h1) ? "prom" : "above prom", addr);
                ioctl_write(addr, data);
                if (kind == 4'h1) begin
                    prom_exp[exp_a[8:0]] = data[3:0];
                    prom_set[exp_a[8:0]] = 1'b1;
                end
                prom_rd_addr = exp_a[8:0];
                step_cycle();
                if (prom_set[exp_a[8:0]] && prom_rd_data !== prom_exp[exp_a[8:0]])
                    flag_mismatch("prom_rd_data", 32'(prom_exp[exp_a[8:0]]), 32'(prom_rd_data));
                step_cycle();
                if (req_count != reqs_before) note_error("PROM window write raised prog_we");
            end
            4'h2: begin
                test_name = $sformatf("timeout %h", addr);
                no_ack = 1'b1;
                ioctl_write(addr, data);
                check_request(exp_a, data, mask);
                downloading = 1'b0;  // Pending request alone keeps the loader busy
                cycles = 0;
                while (prog_we && cycles < ACK_TIMEOUT + 2) begin
                    step_cycle();
                    cycles++;
                    if (cycles == 1 && dwnld_busy !== 1'b1)
                        note_error("dwnld_busy low while a request is pending");
                end
                if (prog_we) note_error("prog_we still high after the ack timeout");
                if (ack_timeout !== err)
                    flag_mismatch("ack_timeout", 32'(err), 32'(ack_timeout));
                restart_download();
                no_ack = 1'b0;
                if (ack_timeout !== 1'b0) note_error("ack_timeout did not clear on a new download");
            end
            4'h4: begin
                test_name = $sformatf("overrun %h", addr);
                ioctl_write(addr, data);
                ioctl_write(addr ^ 25'h2, ~data);   // Lands while the request is pending
                check_request(exp_a, data, mask);
                wait_idle();
                if (req_count != reqs_before + 1) note_error("dropped write raised a request");
                if (overrun !== err) flag_mismatch("overrun", 32'(err), 32'(overrun));
                restart_download();
                if (overrun !== 1'b0) note_error("overrun did not clear on a new download");
            end
            default: begin
                test_name = $sformatf("vector %0d", idx);
                note_error("unknown target code in the test data");
            end
        endcase
        close_test(errs_before);
    endtask

    task automatic prom_readback();
        int errs_before;

        errs_before = total_errors();
        test_name   = "prom readback";
        for (int a = 0; a < 512; a++) begin
            if (prom_set[a]) begin
                prom_rd_addr = 9'(a);
                step_cycle();
                if (prom_rd_data !== prom_exp[a])
                    flag_mismatch($sformatf("entry %h", a), 32'(prom_exp[a]), 32'(prom_rd_data));
            end
        end
        close_test(errs_before);
    endtask

    initial begin
        int n;

        void'($urandom(32'h33e8));
        clk          = 1'b0;
        rst_n        = 1'b0;
        downloading  = 1'b0;
        ioctl_addr   = '0;
        ioctl_dout   = '0;
        ioctl_wr     = 1'b0;
        prom_rd_addr = '0;
        no_ack       = 1'b0;
        errors       = 0;
        hs_errors    = 0;
        tests_ok     = 0;
        tests_bad    = 0;
        req_count    = 0;
        test_name    = "reset";
        for (int a = 0; a < 512; a++) prom_set[a] = 1'b0;
        $readmemh("tests/kicker_testdata.hex", vec);
        n = 0;
        while (n < MAX_VEC && vec[n*COLS+4] !== 32'hf) n++;
        num_vec = n;

        repeat (16) @(posedge clk);
        #1;
        rst_n       = 1'b1;
        downloading = 1'b1;
        step_cycle();

        for (int i = 0; i < num_vec; i++) run_vector(i);
        wait_idle();
        prom_readback();

        $display("%0d tests: %0d ok, %0d failed, %0d errors", tests_ok + tests_bad,
                 tests_ok, tests_bad, total_errors());
        if (total_errors() == 0 && tests_bad == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Bound from the vector count and the worst-case handshake length
    initial begin
        wait (num_vec > 0);
        repeat (num_vec * (2 * ACK_TIMEOUT + 20) + 200) @(posedge clk);
        $display("Watchdog expired before the last test finished");
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- kicker_rom_loader.f
src/kicker_pkg.sv
src/kicker_prog_latch.sv
src/kicker_dwnld_fsm.sv
src/kicker_ack_timer.sv
src/kicker_prom_store.sv
src/kicker_rom_loader.sv
tests/kicker_sdram_model.sv
tests/tb_kicker_rom_loader.sv

//--- Makefile
TOP := tb_kicker_rom_loader

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f kicker_rom_loader.f

sim:
	verilator --binary --timing -j 0 --top-module $(TOP) -f kicker_rom_loader.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx 'test passed'

clean:
	rm -rf obj_dir

//--- tests/kicker_testdata.hex
// addr   data  exp_addr  mask  target  err
// target 0 sdram, 1 prom (exp_addr = entry), 2 timeout, 3 above prom, 4 overrun, f end
00000 12 000000 2 0 0
01235 a5 00091a 1 0 0
0fffe 3c 007fff 2 0 0
10000 81 008001 2 0 0
10013 c4 008002 1 0 0
1000e 9d 00800f 2 0 0
18000 e7 00c003 2 0 0
1803b 5e 00c014 1 0 0
18070 2f 00c020 2 0 0
20000 3b 000000 0 1 0
20005 46 000005 0 1 0
20080 09 000080 0 1 0
201ff fe 0001ff 0 1 0
20205 0c 000005 0 3 0
02000 5a 001000 2 2 1
18002 11 00c007 2 0 0
00100 77 000080 2 4 1
0 0 0 0 f 0
